/* common/fifo_cfg_pkg.sv */
// ----------------------------------------------------------
// FIFO configuration constants
// Storage depth, word width and static flag thresholds
// ----------------------------------------------------------

`default_nettype none

package fifo_cfg_pkg;

   // ----------------------------------------------------------
   // Storage geometry
   // ----------------------------------------------------------
   localparam int DEPTH  = 16;          // Number of storage words
   localparam int ADDR_W = 4;           // Address width, log2 of DEPTH
   localparam int CNT_W  = 5;           // Count width, must hold DEPTH itself
   localparam int DATA_W = 18;          // Data word width

   // ----------------------------------------------------------
   // Static thresholds
   // ----------------------------------------------------------
   // Almost-full holds at or above this occupancy
   localparam int AFULL_VAL  = 12;
   // Almost-empty holds at or below this occupancy
   localparam int AEMPTY_VAL = 4;

endpackage : fifo_cfg_pkg

`default_nettype wire

/* common/fifo_types_pkg.sv */
// ----------------------------------------------------------
// FIFO shared types
// Operation encoding and the bundles passed between the
// access, level and RAM blocks
// ----------------------------------------------------------

`default_nettype none

package fifo_types_pkg;

   // Accepted operation of the current cycle
   typedef enum logic [1:0] {
      op_idle     = 2'b00,    // Nothing accepted
      op_push     = 2'b01,    // Write only
      op_pop      = 2'b10,    // Read only
      op_push_pop = 2'b11     // Write and read together, count holds
   } fifo_op_e;

   // ----------------------------------------------------------
   // Status seen by the access block and the top level
   // ----------------------------------------------------------
   typedef struct packed {
      logic                             full;     // Count equals DEPTH
      logic                             afull;    // Count at or above AFULL_VAL
      logic                             empty;    // Count is zero
      logic                             aempty;   // Count at or below AEMPTY_VAL
      logic [fifo_cfg_pkg::CNT_W-1:0]   count;    // Live occupancy
   } fifo_status_t;

   // ----------------------------------------------------------
   // RAM port bundles
   // ----------------------------------------------------------
   typedef struct packed {
      logic                             we;       // Write strobe
      logic [fifo_cfg_pkg::ADDR_W-1:0]  waddr;    // Write address
      logic [fifo_cfg_pkg::DATA_W-1:0]  wdata;    // Write data
   } mem_wr_t;

   typedef struct packed {
      logic                             re;       // Read strobe
      logic [fifo_cfg_pkg::ADDR_W-1:0]  raddr;    // Read address
   } mem_rd_t;

endpackage : fifo_types_pkg

`default_nettype wire

/* verilog/fifo_ram.sv */
// ----------------------------------------------------------
// FIFO storage RAM
// Simple dual-port array, one write and one registered read
// per cycle
// ----------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module fifo_ram (
   input  wire logic                              pos_clk,
   input  wire fifo_types_pkg::mem_wr_t           mem_wr_i,
   input  wire fifo_types_pkg::mem_rd_t           mem_rd_i,
   output      logic [fifo_cfg_pkg::DATA_W-1:0]   rd_data_o
);

   // DEPTH x DATA_W storage
   logic [fifo_cfg_pkg::DATA_W-1:0] mem [fifo_cfg_pkg::DEPTH];

   // Write port
   always_ff @(posedge pos_clk) begin
      if (mem_wr_i.we) begin
         mem[mem_wr_i.waddr] <= mem_wr_i.wdata;
      end
   end

   // Read port, data valid on the next cycle
   always_ff @(posedge pos_clk) begin
      if (mem_rd_i.re) begin
         rd_data_o <= mem[mem_rd_i.raddr];    // Holds last word otherwise
      end
   end

endmodule : fifo_ram

`default_nettype wire

/* verilog/fifo_level.sv */
// ----------------------------------------------------------
// FIFO occupancy tracking
// Single up/down counter of stored words. Flags are
// registered from the next count so they track it exactly
// ----------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module fifo_level (
   input  wire logic                          pos_clk,
   input  wire logic                          aresetn,
   input  wire fifo_types_pkg::fifo_op_e      op_i,
   output      fifo_types_pkg::fifo_status_t  status_o
);

   logic [fifo_cfg_pkg::CNT_W-1:0]   count_q;    // Current occupancy
   logic [fifo_cfg_pkg::CNT_W-1:0]   count_d;    // Occupancy after this cycle's op
   logic                             full_d;
   logic                             afull_d;
   logic                             empty_d;
   logic                             aempty_d;
   logic                             full_q;
   logic                             afull_q;
   logic                             empty_q;
   logic                             aempty_q;

   // ----------------------------------------------------------
   // Next count
   // ----------------------------------------------------------
   always_comb begin
      unique case (op_i)
         fifo_types_pkg::op_push: count_d = count_q + 1'b1;
         fifo_types_pkg::op_pop:  count_d = count_q - 1'b1;
         // Idle and simultaneous push/pop both hold
         default:                 count_d = count_q;
      endcase
   end

   // Flags as pure functions of the next count
   assign full_d   = (count_d == fifo_cfg_pkg::DEPTH);
   assign empty_d  = (count_d == '0);
   assign afull_d  = (count_d >= fifo_cfg_pkg::AFULL_VAL);
   assign aempty_d = (count_d <= fifo_cfg_pkg::AEMPTY_VAL);

   // ----------------------------------------------------------
   // Count and flag registers
   // ----------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         count_q  <= '0;
         full_q   <= 1'b0;
         afull_q  <= 1'b0;
         empty_q  <= 1'b1;      // Starts empty
         aempty_q <= 1'b1;
      end else begin
         count_q  <= count_d;
         full_q   <= full_d;
         afull_q  <= afull_d;
         empty_q  <= empty_d;
         aempty_q <= aempty_d;
      end
   end

   // Status bundle out
   assign status_o = '{
      full:   full_q,
      afull:  afull_q,
      empty:  empty_q,
      aempty: aempty_q,
      count:  count_q
   };

endmodule : fifo_level

`default_nettype wire

/* verilog/fifo_access.sv */
// ----------------------------------------------------------
// FIFO access control
// Qualifies write/read enables with full/empty, keeps the
// wrapping RAM addresses and registers ack, valid and error
// pulses
// ----------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module fifo_access (
   input  wire logic                              pos_clk,
   input  wire logic                              aresetn,
   input  wire logic                              wr_en_i,
   input  wire logic [fifo_cfg_pkg::DATA_W-1:0]   wr_data_i,
   input  wire logic                              rd_en_i,
   input  wire fifo_types_pkg::fifo_status_t      status_i,
   output      fifo_types_pkg::mem_wr_t           mem_wr_o,
   output      fifo_types_pkg::mem_rd_t           mem_rd_o,
   output      fifo_types_pkg::fifo_op_e          op_o,
   output      logic                              wack_o,
   output      logic                              dvld_o,
   output      logic                              overflow_o,
   output      logic                              underflow_o
);

   logic                              we_acc;    // Write accepted this cycle
   logic                              re_acc;    // Read accepted this cycle
   logic [fifo_cfg_pkg::ADDR_W-1:0]   waddr_q;
   logic [fifo_cfg_pkg::ADDR_W-1:0]   raddr_q;

   // Address step with explicit wrap at DEPTH-1
   function automatic logic [fifo_cfg_pkg::ADDR_W-1:0] next_addr(
      input logic [fifo_cfg_pkg::ADDR_W-1:0] addr
   );
      if (addr == fifo_cfg_pkg::DEPTH - 1) begin
         return '0;
      end
      return addr + 1'b1;
   endfunction

   // ----------------------------------------------------------
   // Acceptance and op encoding
   // ----------------------------------------------------------
   assign we_acc = wr_en_i & ~status_i.full;     // Refused while full
   assign re_acc = rd_en_i & ~status_i.empty;    // Refused while empty

   always_comb begin
      unique case ({re_acc, we_acc})
         2'b01:   op_o = fifo_types_pkg::op_push;
         2'b10:   op_o = fifo_types_pkg::op_pop;
         2'b11:   op_o = fifo_types_pkg::op_push_pop;
         default: op_o = fifo_types_pkg::op_idle;
      endcase
   end

   // RAM ports, strobes go straight through
   assign mem_wr_o = '{we: we_acc, waddr: waddr_q, wdata: wr_data_i};
   assign mem_rd_o = '{re: re_acc, raddr: raddr_q};

   // ----------------------------------------------------------
   // Addresses and pulses
   // ----------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         waddr_q     <= '0;
         raddr_q     <= '0;
         wack_o      <= 1'b0;
         dvld_o      <= 1'b0;
         overflow_o  <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         if (we_acc) waddr_q <= next_addr(waddr_q);
         if (re_acc) raddr_q <= next_addr(raddr_q);
         wack_o      <= we_acc;                       // One cycle after write
         dvld_o      <= re_acc;                       // Lines up with RAM read data
         overflow_o  <= wr_en_i & status_i.full;      // Write attempt while full
         underflow_o <= rd_en_i & status_i.empty;     // Read attempt while empty
      end
   end

endmodule : fifo_access

`default_nettype wire

/* verilog/sync_fifo_top.sv */
// ----------------------------------------------------------
// Single-clock FIFO, top level
// Ties access control, occupancy tracking and storage RAM
// together. Standard read mode, data one cycle after read
// ----------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module sync_fifo_top (
   input  wire logic                              pos_clk,
   input  wire logic                              aresetn,
   // Write side
   input  wire logic                              wr_en_i,
   input  wire logic [fifo_cfg_pkg::DATA_W-1:0]   wr_data_i,
   // Read side
   input  wire logic                              rd_en_i,
   output      logic [fifo_cfg_pkg::DATA_W-1:0]   rd_data_o,
   // Handshake and error pulses
   output      logic                              dvld_o,
   output      logic                              wack_o,
   output      logic                              overflow_o,
   output      logic                              underflow_o,
   // Flags and live count
   output      fifo_types_pkg::fifo_status_t      status_o
);

   // ----------------------------------------------------------
   // Internal wiring
   // ----------------------------------------------------------
   fifo_types_pkg::mem_wr_t   mem_wr;     // Access -> RAM write port
   fifo_types_pkg::mem_rd_t   mem_rd;     // Access -> RAM read port
   fifo_types_pkg::fifo_op_e  op;         // Access -> level, accepted op

   // Enable qualification, addresses and pulses
   fifo_access i_fifo_access (
      .pos_clk      (pos_clk),
      .aresetn      (aresetn),
      .wr_en_i      (wr_en_i),
      .wr_data_i    (wr_data_i),
      .rd_en_i      (rd_en_i),
      .status_i     (status_o),
      .mem_wr_o     (mem_wr),
      .mem_rd_o     (mem_rd),
      .op_o         (op),
      .wack_o       (wack_o),
      .dvld_o       (dvld_o),
      .overflow_o   (overflow_o),
      .underflow_o  (underflow_o)
   );

   // Count and flags, sole owner
   fifo_level i_fifo_level (
      .pos_clk   (pos_clk),
      .aresetn   (aresetn),
      .op_i      (op),
      .status_o  (status_o)
   );

   // Storage with registered read
   fifo_ram i_fifo_ram (
      .pos_clk    (pos_clk),
      .mem_wr_i   (mem_wr),
      .mem_rd_i   (mem_rd),
      .rd_data_o  (rd_data_o)
   );

endmodule : sync_fifo_top

`default_nettype wire

/* verif/sync_fifo_sva.sv */
// ----------------------------------------------------------
// FIFO protocol assertions bound into the top level
// Flag functions, pulse timing and count hold on push_pop
// ----------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module sync_fifo_sva (
   input wire logic                           pos_clk,
   input wire logic                           aresetn,
   input wire logic                           wr_en_i,
   input wire logic                           rd_en_i,
   input wire logic                           wack_i,
   input wire logic                           dvld_i,
   input wire logic                           ovf_i,
   input wire logic                           udf_i,
   input wire fifo_types_pkg::fifo_status_t   status_i,
   input wire fifo_types_pkg::fifo_op_e       op_i
);

   // Flags follow the count exactly
   a_flags: assert property (@(posedge pos_clk) disable iff (!aresetn)
      status_i.full == (int'(status_i.count) == fifo_cfg_pkg::DEPTH) &&
      status_i.empty == (int'(status_i.count) == 0) &&
      status_i.afull == (int'(status_i.count) >= fifo_cfg_pkg::AFULL_VAL) &&
      status_i.aempty == (int'(status_i.count) <= fifo_cfg_pkg::AEMPTY_VAL))
      else $error("Flags disagree with count");

   a_bound: assert property (@(posedge pos_clk) disable iff (!aresetn)
      int'(status_i.count) <= fifo_cfg_pkg::DEPTH) else $error("Count beyond depth");

   // Pulses one cycle after the qualifying cycle
   a_wack: assert property (@(posedge pos_clk) disable iff (!aresetn)
      wack_i == $past(wr_en_i && !status_i.full)) else $error("Write ack timing");
   a_dvld: assert property (@(posedge pos_clk) disable iff (!aresetn)
      dvld_i == $past(rd_en_i && !status_i.empty)) else $error("Data valid timing");
   a_ovf: assert property (@(posedge pos_clk) disable iff (!aresetn)
      ovf_i == $past(wr_en_i && status_i.full)) else $error("Overflow timing");
   a_udf: assert property (@(posedge pos_clk) disable iff (!aresetn)
      udf_i == $past(rd_en_i && status_i.empty)) else $error("Underflow timing");

   a_hold: assert property (@(posedge pos_clk) disable iff (!aresetn)
      op_i == fifo_types_pkg::op_push_pop |=> $stable(status_i.count))
      else $error("Count moved on push_pop");

endmodule : sync_fifo_sva

bind sync_fifo_top sync_fifo_sva i_sync_fifo_sva (
   .pos_clk   (pos_clk),
   .aresetn   (aresetn),
   .wr_en_i   (wr_en_i),
   .rd_en_i   (rd_en_i),
   .wack_i    (wack_o),
   .dvld_i    (dvld_o),
   .ovf_i     (overflow_o),
   .udf_i     (underflow_o),
   .status_i  (status_o),
   .op_i      (op)
);

`default_nettype wire

/* verif/tb_sync_fifo.sv */
// ----------------------------------------------------------
// Testbench for the single-clock FIFO
// Fill, drain and random phases against a reference queue
// ----------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module tb_sync_fifo;

   localparam int          CLK_PERIOD  = 8;
   localparam int          RESET_CYC   = 4;
   localparam int          RAND_CYC    = 400;
   localparam logic [31:0] SEED        = 32'hd6f6130a;
   // Stimulus runs under 500 cycles and the limit is about three times that
   localparam int          TIMEOUT_CYC = 1500;
   localparam int          WR_BIAS [4] = '{12, 4, 8, 14};   // Out of 16
   localparam int          RD_BIAS [4] = '{4, 12, 8, 14};

   logic                                pos_clk;
   logic                                aresetn;
   logic                                wr_en_i;
   logic                                rd_en_i;
   logic [fifo_cfg_pkg::DATA_W-1:0]     wr_data_i;
   logic [fifo_cfg_pkg::DATA_W-1:0]     rd_data_o;
   logic                                dvld_o;
   logic                                wack_o;
   logic                                overflow_o;
   logic                                underflow_o;
   fifo_types_pkg::fifo_status_t        status_o;

   logic [31:0]                         lfsr_state;
   logic [fifo_cfg_pkg::DATA_W-1:0]     ref_q [$];     // Words in write order
   logic [fifo_cfg_pkg::DATA_W-1:0]     exp_data;
   logic                                exp_wack;
   logic                                exp_dvld;
   logic                                exp_ovf;
   logic                                exp_udf;
   int                                  model_cnt;
   int                                  cycle_cnt = 0;

   sync_fifo_top i_sync_fifo_top (.*);

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v          = {v[30:0], lfsr_state[0]};
      end
   endtask

   task automatic fail_now(input string line);
      $display("%s", line);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic mismatch(input string msg);
      fail_now($sformatf("Mismatch at %0t ns: %s", $time, msg));
   endtask

   // Drive on the rising edge, return at the falling edge
   task automatic drive_cycle(input logic wr, input logic rd);
      logic [31:0] rnd;
      take_bits(fifo_cfg_pkg::DATA_W, rnd);
      @(posedge pos_clk);
      wr_en_i   <= wr;
      rd_en_i   <= rd;
      wr_data_i <= rnd[fifo_cfg_pkg::DATA_W-1:0];
      @(negedge pos_clk);
   endtask

   initial begin
      pos_clk = 1'b0;
      forever #(CLK_PERIOD / 2) pos_clk = ~pos_clk;
   end

   // ----------------------------------------------------------
   // Reference model and checks at mid-cycle where all is stable
   // ----------------------------------------------------------
   always @(negedge pos_clk) begin : check_and_model
      logic wacc;
      logic racc;
      if (!aresetn) begin
         ref_q.delete();
         model_cnt = 0;
         {exp_wack, exp_dvld, exp_ovf, exp_udf} = '0;
      end else begin
         assert (int'(status_o.count) == model_cnt)
            else mismatch($sformatf("count %0d, expected %0d", status_o.count, model_cnt));
         assert (status_o.full == (model_cnt == fifo_cfg_pkg::DEPTH)) else mismatch("full flag");
         assert (status_o.empty == (model_cnt == 0)) else mismatch("empty flag");
         assert (status_o.afull == (model_cnt >= fifo_cfg_pkg::AFULL_VAL))
            else mismatch("almost-full flag");
         assert (status_o.aempty == (model_cnt <= fifo_cfg_pkg::AEMPTY_VAL))
            else mismatch("almost-empty flag");
         assert (wack_o == exp_wack) else mismatch("write ack pulse");
         assert (dvld_o == exp_dvld) else mismatch("data valid pulse");
         assert (overflow_o == exp_ovf) else mismatch("overflow pulse");
         assert (underflow_o == exp_udf) else mismatch("underflow pulse");
         if (exp_dvld) begin
            assert (rd_data_o == exp_data)
               else mismatch($sformatf("read data %h, expected %h", rd_data_o, exp_data));
         end
         // Acceptance rules for the ops taken on the next edge
         wacc     = wr_en_i && (model_cnt != fifo_cfg_pkg::DEPTH);
         racc     = rd_en_i && (model_cnt != 0);
         exp_wack = wacc;
         exp_dvld = racc;
         exp_ovf  = wr_en_i && (model_cnt == fifo_cfg_pkg::DEPTH);
         exp_udf  = rd_en_i && (model_cnt == 0);
         if (racc) exp_data = ref_q.pop_front();     // Oldest word
         if (wacc) ref_q.push_back(wr_data_i);
         model_cnt = model_cnt + int'(wacc) - int'(racc);
      end
   end

   // Run limit
   always @(posedge pos_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYC) begin
         fail_now("Timeout: run did not finish within the cycle limit");
      end
   end

   // ----------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------
   initial begin
      logic [31:0] rnd;
      logic        wr_bit;
      logic        rd_bit;
      aresetn    = 1'b0;
      wr_en_i    = 1'b0;
      rd_en_i    = 1'b0;
      wr_data_i  = '0;
      lfsr_state = SEED;
      repeat (RESET_CYC) @(posedge pos_clk);
      aresetn <= 1'b1;
      @(negedge pos_clk);
      while (!status_o.full) drive_cycle(1'b1, 1'b0);    // Fill burst
      repeat (3) drive_cycle(1'b1, 1'b0);                // Overflow attempts
      while (!status_o.empty) drive_cycle(1'b0, 1'b1);   // Drain burst
      repeat (3) drive_cycle(1'b0, 1'b1);                // Underflow attempts
      for (int seg = 0; seg < 4; seg++) begin
         repeat (RAND_CYC / 4) begin
            take_bits(4, rnd);
            wr_bit = (int'(rnd[3:0]) < WR_BIAS[seg]);
            take_bits(4, rnd);
            rd_bit = (int'(rnd[3:0]) < RD_BIAS[seg]);
            drive_cycle(wr_bit, rd_bit);
         end
      end
      repeat (4) drive_cycle(1'b0, 1'b0);                // Flush last read
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule : tb_sync_fifo

`default_nettype wire

/* tb.f */
common/fifo_cfg_pkg.sv
common/fifo_types_pkg.sv
verilog/fifo_ram.sv
verilog/fifo_level.sv
verilog/fifo_access.sv
verilog/sync_fifo_top.sv
verif/sync_fifo_sva.sv
verif/tb_sync_fifo.sv

/* run.sh */
#!/bin/sh
# Build and run the FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_sync_fifo \
   -f tb.f

# Simulation exit status is not trusted, the log decides
./obj_dir/Vtb_sync_fifo > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
   exit 0
else
   exit 1
fi
